/* flist.f */
+incdir+source
source/core_pkg.sv
source/instr_decode.sv
source/alu.sv
source/execute_stage.sv
source/result_stage.sv
source/exec_core.sv
testbench/exec_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the exec_core testbench with Verilator.

set -u
cd "$(dirname "$0")"

log_file=sim.log
sim_bin=sim_exec_core

verilator --binary --timing -f flist.f --top-module exec_core_tb -o "$sim_bin"
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/"$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# The run only counts as passed if the testbench printed its pass line.
grep -q '^\*\* PASS \*\*$' "$log_file"
if [ $? -ne 0 ]; then
    echo "simulation did not pass, see $log_file"
    exit 1
fi

echo "simulation passed"
exit 0

/* source/alu.sv */
`include "core_defs.svh"

module alu
    import core_pkg::*;
(
    input  alu_op_e          alu_op,
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    output logic [`XLEN-1:0] value,
    output logic             cond
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // only the low five bits of b count as the shift amount.
    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        value = '0;
        cond  = 1'b0;
        case (alu_op)
            ALU_ADD:    value = a + b;
            ALU_SUB:    value = a - b;
            ALU_SLL:    value = a << shamt;
            ALU_SLT:    value[0] = lt_signed;
            ALU_SLTU:   value[0] = lt_unsigned;
            ALU_XOR:    value = a ^ b;
            ALU_SRL:    value = a >> shamt;
            ALU_SRA:    value = $signed(a) >>> shamt;
            ALU_OR:     value = a | b;
            ALU_AND:    value = a & b;
            // branch compares drive cond only and leave value at zero.
            ALU_BEQ:    cond = (a == b);
            ALU_BNE:    cond = (a != b);
            ALU_BLT:    cond = lt_signed;
            ALU_BGE:    cond = !lt_signed;
            ALU_BLTU:   cond = lt_unsigned;
            ALU_BGEU:   cond = !lt_unsigned;
            ALU_PASS_B: value = b;
            default: begin
                value = '0;
                cond  = 1'b0;
            end
        endcase
    end

endmodule

/* source/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// ########################################
// core widths and sizes
// ########################################

// data and address width of the core.
`define XLEN 32

// architectural register file size and index width.
`define REG_COUNT 32
`define REG_ADDR_W 5

`endif

/* source/core_pkg.sv */
`include "core_defs.svh"

package core_pkg;

    // ########################################
    // encodings
    // ########################################

    // major opcodes handled by the core.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU,
        ALU_PASS_B,
        ALU_NONE
    } alu_op_e;

    // ########################################
    // stage records
    // ########################################

    typedef struct packed {
        logic                   valid;
        alu_op_e                alu_op;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   use_imm;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       pc;
        logic                   write_en;
        logic                   branch;
        logic                   illegal;
    } decoded_t;

    // write_en is already false for rd of x0 here.
    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   write_en;
        logic [`XLEN-1:0]       value;
        logic                   branch;
        logic                   taken;
        logic [`XLEN-1:0]       target;
        logic                   illegal;
    } exec_t;

    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   write_en;
        logic [`XLEN-1:0]       value;
        logic                   branch;
        logic                   taken;
        logic [`XLEN-1:0]       target;
        logic                   illegal;
    } result_t;

endpackage

/* source/exec_core.sv */
`include "core_defs.svh"

module exec_core
    import core_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  logic [`XLEN-1:0] in_instr,
    input  logic [`XLEN-1:0] in_pc,
    output result_t          result
);

    decoded_t               decoded;
    exec_t                  executed;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;

    instr_decode instr_decode_inst (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .in_pc    (in_pc),
        .decoded  (decoded)
    );

    // execute reads operands from the register file held in the result stage.
    execute_stage execute_stage_inst (
        .clk      (clk),
        .reset    (reset),
        .decoded  (decoded),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .executed (executed)
    );

    result_stage result_stage_inst (
        .clk      (clk),
        .reset    (reset),
        .executed (executed),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (result)
    );

endmodule

/* source/execute_stage.sv */
`include "core_defs.svh"

module execute_stage
    import core_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  decoded_t               decoded,
    output logic [`REG_ADDR_W-1:0] rs1_addr,
    output logic [`REG_ADDR_W-1:0] rs2_addr,
    input  logic [`XLEN-1:0]       rs1_data,
    input  logic [`XLEN-1:0]       rs2_data,
    output exec_t                  executed
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_value;
    logic             alu_cond;
    exec_t            exec_next;

    assign rs1_addr = decoded.rs1;
    assign rs2_addr = decoded.rs2;

    // the previous instruction is still in executed and not yet in the
    // register file. write_en is never set for x0, so x0 is not forwarded.
    always_comb begin
        op_a    = rs1_data;
        rs2_val = rs2_data;
        if (executed.valid && executed.write_en && executed.rd == decoded.rs1)
            op_a = executed.value;
        if (executed.valid && executed.write_en && executed.rd == decoded.rs2)
            rs2_val = executed.value;
    end

    assign op_b = decoded.use_imm ? decoded.imm : rs2_val;

    alu alu_inst (
        .alu_op (decoded.alu_op),
        .a      (op_a),
        .b      (op_b),
        .value  (alu_value),
        .cond   (alu_cond)
    );

    always_comb begin
        exec_next.valid    = decoded.valid;
        exec_next.rd       = decoded.rd;
        exec_next.write_en = decoded.valid && decoded.write_en && (decoded.rd != '0);
        exec_next.value    = alu_value;
        exec_next.branch   = decoded.branch;
        exec_next.taken    = decoded.branch && alu_cond;
        exec_next.target   = decoded.pc + decoded.imm;
        exec_next.illegal  = decoded.illegal;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            executed.valid <= 1'b0;
        end else begin
            executed <= exec_next;
        end
    end

endmodule

/* source/instr_decode.sv */
`include "core_defs.svh"

module instr_decode
    import core_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  logic [`XLEN-1:0] in_instr,
    input  logic [`XLEN-1:0] in_pc,
    output decoded_t         decoded
);

    opcode_e          opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_b;
    decoded_t         dec_next;

    assign opcode = opcode_e'(in_instr[6:0]);
    assign funct3 = in_instr[14:12];
    assign funct7 = in_instr[31:25];

    assign imm_i = {{20{in_instr[31]}}, in_instr[31:20]};
    assign imm_u = {in_instr[31:12], 12'b0};
    assign imm_b = {{19{in_instr[31]}}, in_instr[31], in_instr[7],
                    in_instr[30:25], in_instr[11:8], 1'b0};

    always_comb begin
        dec_next          = '0;
        dec_next.valid    = in_valid;
        dec_next.alu_op   = ALU_NONE;
        dec_next.rs1      = in_instr[19:15];
        dec_next.rs2      = in_instr[24:20];
        dec_next.rd       = in_instr[11:7];
        dec_next.imm      = imm_i;
        dec_next.pc       = in_pc;

        case (opcode)
            OPC_OP: begin
                dec_next.write_en = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: dec_next.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: dec_next.alu_op = ALU_SUB;
                    {7'b0000000, 3'b001}: dec_next.alu_op = ALU_SLL;
                    {7'b0000000, 3'b010}: dec_next.alu_op = ALU_SLT;
                    {7'b0000000, 3'b011}: dec_next.alu_op = ALU_SLTU;
                    {7'b0000000, 3'b100}: dec_next.alu_op = ALU_XOR;
                    {7'b0000000, 3'b101}: dec_next.alu_op = ALU_SRL;
                    {7'b0100000, 3'b101}: dec_next.alu_op = ALU_SRA;
                    {7'b0000000, 3'b110}: dec_next.alu_op = ALU_OR;
                    {7'b0000000, 3'b111}: dec_next.alu_op = ALU_AND;
                    default:              dec_next.illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                dec_next.write_en = 1'b1;
                dec_next.use_imm  = 1'b1;
                case (funct3)
                    3'b000: dec_next.alu_op = ALU_ADD;
                    3'b010: dec_next.alu_op = ALU_SLT;
                    3'b011: dec_next.alu_op = ALU_SLTU;
                    3'b100: dec_next.alu_op = ALU_XOR;
                    3'b110: dec_next.alu_op = ALU_OR;
                    3'b111: dec_next.alu_op = ALU_AND;
                    3'b001: begin
                        if (funct7 == 7'b0000000) dec_next.alu_op = ALU_SLL;
                        else dec_next.illegal = 1'b1;
                    end
                    default: begin
                        // funct3 101 selects the right shifts by funct7.
                        if (funct7 == 7'b0000000) dec_next.alu_op = ALU_SRL;
                        else if (funct7 == 7'b0100000) dec_next.alu_op = ALU_SRA;
                        else dec_next.illegal = 1'b1;
                    end
                endcase
            end
            OPC_LUI: begin
                dec_next.write_en = 1'b1;
                dec_next.use_imm  = 1'b1;
                dec_next.imm      = imm_u;
                dec_next.alu_op   = ALU_PASS_B;
            end
            OPC_BRANCH: begin
                dec_next.branch = 1'b1;
                dec_next.imm    = imm_b;
                case (funct3)
                    3'b000:  dec_next.alu_op = ALU_BEQ;
                    3'b001:  dec_next.alu_op = ALU_BNE;
                    3'b100:  dec_next.alu_op = ALU_BLT;
                    3'b101:  dec_next.alu_op = ALU_BGE;
                    3'b110:  dec_next.alu_op = ALU_BLTU;
                    3'b111:  dec_next.alu_op = ALU_BGEU;
                    default: dec_next.illegal = 1'b1;
                endcase
            end
            default: dec_next.illegal = 1'b1;
        endcase

        // an illegal word must not write or branch.
        if (dec_next.illegal) begin
            dec_next.write_en = 1'b0;
            dec_next.branch   = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded.valid <= 1'b0;
        end else begin
            decoded <= dec_next;
        end
    end

endmodule

/* source/result_stage.sv */
`include "core_defs.svh"

module result_stage
    import core_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  exec_t                  executed,
    input  logic [`REG_ADDR_W-1:0] rs1_addr,
    input  logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic [`XLEN-1:0]       rs1_data,
    output logic [`XLEN-1:0]       rs2_data,
    output result_t                result
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    // ########################################
    // register file
    // ########################################

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (executed.valid && executed.write_en) begin
            regs[executed.rd] <= executed.value;
        end
    end

    // x0 reads as zero whatever was stored there.
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // ########################################
    // result record
    // ########################################

    always_ff @(posedge clk) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else begin
            result.valid    <= executed.valid;
            result.rd       <= executed.rd;
            result.write_en <= executed.write_en;
            result.value    <= executed.value;
            result.branch   <= executed.branch;
            result.taken    <= executed.taken;
            result.target   <= executed.target;
            result.illegal  <= executed.illegal;
        end
    end

endmodule

/* testbench/exec_core_tb.sv */
`include "core_defs.svh"

module exec_core_tb
    import core_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_DIRECTED = 12;
    localparam int NUM_RANDOM   = 400;
    localparam int NUM_INSTR    = NUM_DIRECTED + NUM_RANDOM;
    localparam int PIPE_DEPTH   = 3;
    localparam int RESET_CYCLES = 16;
    localparam int TIMEOUT_NS   = (NUM_INSTR * 3 + RESET_CYCLES + 50) * 20;

    logic             clk = 1'b0;
    logic             reset;
    logic             in_valid;
    logic [`XLEN-1:0] in_instr;
    logic [`XLEN-1:0] in_pc;
    result_t          result;

    logic [`XLEN-1:0] ref_regs [`REG_COUNT];
    logic [31:0]      lcg_state = 32'ha6e6_8d33;
    result_t          exp_q [$];
    int               due_q [$];
    int               cycle = 0;

    exec_core exec_core_inst (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .in_pc    (in_pc),
        .result   (result)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // ########################################
    // stimulus helpers
    // ########################################

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [12:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    // registers come from x0 to x7 so that dependences show up often.
    function automatic logic [31:0] random_instr();
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] instr;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        r   = next_rand();
        s   = next_rand();
        rd  = {2'b00, r[18:16]};
        rs1 = {2'b00, r[21:19]};
        rs2 = {2'b00, r[24:22]};
        f3  = r[27:25];
        imm = s[31:20];
        f7  = ((f3 == 3'b000 || f3 == 3'b101) && s[0]) ? 7'h20 : 7'h00;
        if (r[31:28] < 4'd5) begin
            instr = enc_r(f7, rs2, rs1, f3, rd);
        end else if (r[31:28] < 4'd10) begin
            if (f3 == 3'b001 || f3 == 3'b101)
                imm[11:5] = (f3 == 3'b101) ? f7 : 7'h00;
            instr = enc_i(imm, rs1, f3, rd);
        end else if (r[31:28] < 4'd11) begin
            instr = {s[31:12], rd, OPC_LUI};
        end else if (r[31:28] < 4'd14) begin
            if (f3 == 3'b010 || f3 == 3'b011)
                f3 = {1'b1, s[1], s[2]};
            instr = enc_branch({s[12:1], 1'b0}, rs2, rs1, f3);
        end else begin
            case (s[4:3])
                2'd0:    instr = enc_r(7'h01, rs2, rs1, f3, rd);
                2'd1:    instr = enc_branch({s[12:1], 1'b0}, rs2, rs1, 3'b010);
                2'd2:    instr = enc_i({7'h20, rs2}, rs1, 3'b001, rd);
                default: instr = {s[31:7], 7'b0000011};
            endcase
        end
        return instr;
    endfunction

    // ########################################
    // reference model
    // ########################################

    function automatic result_t predict(input logic [31:0] instr, input logic [31:0] pc);
        result_t     r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic        alt;
        logic        legal;
        r     = '0;
        opc   = instr[6:0];
        f3    = instr[14:12];
        f7    = instr[31:25];
        alt   = (f7 == 7'h20);
        legal = 1'b1;
        a     = ref_regs[instr[19:15]];
        b     = ref_regs[instr[24:20]];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        r.valid = 1'b1;
        r.rd    = instr[11:7];
        case (opc)
            OPC_OP, OPC_OP_IMM: begin
                if (opc == OPC_OP)
                    legal = (f7 == 7'h00) || (alt && (f3 == 3'b000 || f3 == 3'b101));
                else if (f3 == 3'b001)
                    legal = (f7 == 7'h00);
                else if (f3 == 3'b101)
                    legal = (f7 == 7'h00) || alt;
                if (opc == OPC_OP_IMM)
                    b = imm_i;
                r.write_en = 1'b1;
                case (f3)
                    3'b000:  r.value = (alt && opc == OPC_OP) ? a - b : a + b;
                    3'b001:  r.value = a << b[4:0];
                    3'b010:  r.value = {31'b0, $signed(a) < $signed(b)};
                    3'b011:  r.value = {31'b0, a < b};
                    3'b100:  r.value = a ^ b;
                    3'b101: begin
                        if (alt)
                            r.value = $signed(a) >>> b[4:0];
                        else
                            r.value = a >> b[4:0];
                    end
                    3'b110:  r.value = a | b;
                    default: r.value = a & b;
                endcase
            end
            OPC_LUI: begin
                r.write_en = 1'b1;
                r.value    = {instr[31:12], 12'b0};
            end
            OPC_BRANCH: begin
                r.branch = 1'b1;
                r.target = pc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                 instr[11:8], 1'b0};
                case (f3)
                    3'b000:  r.taken = (a == b);
                    3'b001:  r.taken = (a != b);
                    3'b100:  r.taken = $signed(a) < $signed(b);
                    3'b101:  r.taken = $signed(a) >= $signed(b);
                    3'b110:  r.taken = a < b;
                    3'b111:  r.taken = a >= b;
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            r.illegal  = 1'b1;
            r.write_en = 1'b0;
            r.value    = '0;
            r.branch   = 1'b0;
            r.taken    = 1'b0;
        end
        if (r.rd == 5'd0)
            r.write_en = 1'b0;
        if (r.write_en)
            ref_regs[r.rd] = r.value;
        return r;
    endfunction

    // ########################################
    // checking
    // ########################################

    task automatic run_error(input string what);
        $display("%s at %0t", what, $time);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic field_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("Error at %0t: result.%s got %h expected %h", $time, name, got, exp);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_write(input result_t got, input result_t exp);
        if (got.rd !== exp.rd) field_error("rd", 32'(got.rd), 32'(exp.rd));
        if (got.write_en !== exp.write_en)
            field_error("write_en", 32'(got.write_en), 32'(exp.write_en));
        if (got.value !== exp.value) field_error("value", got.value, exp.value);
        if (got.branch !== 1'b0) field_error("branch", 32'(got.branch), 32'(exp.branch));
        if (got.taken !== exp.taken) field_error("taken", 32'(got.taken), 32'(exp.taken));
        if (got.illegal !== 1'b0) field_error("illegal", 32'(got.illegal), 32'(exp.illegal));
    endtask

    task automatic check_branch(input result_t got, input result_t exp);
        if (got.branch !== 1'b1) field_error("branch", 32'(got.branch), 32'(exp.branch));
        if (got.taken !== exp.taken) field_error("taken", 32'(got.taken), 32'(exp.taken));
        if (got.target !== exp.target) field_error("target", got.target, exp.target);
        if (got.write_en !== 1'b0)
            field_error("write_en", 32'(got.write_en), 32'(exp.write_en));
        if (got.value !== exp.value) field_error("value", got.value, exp.value);
    endtask

    task automatic check_illegal(input result_t got, input result_t exp);
        if (got.illegal !== 1'b1) field_error("illegal", 32'(got.illegal), 32'(exp.illegal));
        if (got.write_en !== 1'b0)
            field_error("write_en", 32'(got.write_en), 32'(exp.write_en));
        if (got.branch !== 1'b0) field_error("branch", 32'(got.branch), 32'(exp.branch));
        if (got.taken !== 1'b0) field_error("taken", 32'(got.taken), 32'(exp.taken));
    endtask

    // results are sampled on the falling edge, well away from the update.
    always @(negedge clk) begin : compare_results
        result_t exp_rec;
        int      due;
        if (reset) begin
            if (result.valid !== 1'b0)
                run_error("result valid was not low while reset was asserted");
        end else if (result.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                run_error("a result appeared with no instruction outstanding");
            end else begin
                exp_rec = exp_q.pop_front();
                due     = due_q.pop_front();
                if (cycle != due)
                    run_error($sformatf("a result came at cycle %0d instead of cycle %0d",
                                        cycle, due));
                if (exp_rec.illegal)
                    check_illegal(result, exp_rec);
                else if (exp_rec.branch)
                    check_branch(result, exp_rec);
                else
                    check_write(result, exp_rec);
            end
        end else if (due_q.size() != 0 && cycle > due_q[0]) begin
            run_error("an expected result did not appear in time");
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout, the results did not all arrive");
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    // ########################################
    // stimulus
    // ########################################

    task automatic send(input logic [31:0] instr);
        logic [31:0] pc;
        pc      = next_rand();
        pc[1:0] = 2'b00;
        @(posedge clk);
        #2;
        in_valid = 1'b1;
        in_instr = instr;
        in_pc    = pc;
        exp_q.push_back(predict(instr, pc));
        due_q.push_back(cycle + PIPE_DEPTH);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            in_valid = 1'b0;
        end
    endtask

    initial begin
        logic [31:0] directed [NUM_DIRECTED];
        logic [31:0] g;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        in_pc    = '0;
        for (int i = 0; i < `REG_COUNT; i++)
            ref_regs[i] = '0;
        directed[0]  = {20'h80000, 5'd1, OPC_LUI};
        directed[1]  = enc_i(12'hfff, 5'd0, 3'b000, 5'd2);
        directed[2]  = enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd3);
        directed[3]  = enc_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd4);
        directed[4]  = enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd5);
        directed[5]  = enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd6);
        directed[6]  = enc_i(12'h005, 5'd2, 3'b000, 5'd0);
        directed[7]  = enc_r(7'h00, 5'd2, 5'd0, 3'b000, 5'd7);
        directed[8]  = enc_branch(13'h0010, 5'd2, 5'd1, 3'b100);
        directed[9]  = enc_branch(13'h1ff8, 5'd2, 5'd1, 3'b111);
        directed[10] = 32'h0000_0000;
        directed[11] = enc_r(7'h20, 5'd4, 5'd3, 3'b000, 5'd3);
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
        idle(2);

        // the directed words go back to back to exercise forwarding.
        for (int i = 0; i < NUM_DIRECTED; i++)
            send(directed[i]);
        idle(1);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            send(random_instr());
            g = next_rand();
            if (g[31:30] != 2'd3 && g[31:30] != 2'd0)
                idle(int'(g[31:30]));
        end
        idle(PIPE_DEPTH + 2);

        if (exp_q.size() != 0) begin
            $display("%0d expected results never appeared", exp_q.size());
            $display("** FAIL **");
            $fatal(1, "results missing at the end of the run");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule
